//--- Bender.yml
package:
  name: calculator

sources:
  # RTL
  - include_dirs:
      - logic
    files:
      - logic/calc_types_pkg.sv
      - logic/calc_ctrl_pkg.sv
      - logic/addition.sv
      - logic/multiply.sv
      - logic/gencon.sv
      - logic/calculator_top.sv

  # Verification
  - target: test
    include_dirs:
      - logic
    files:
      - verification/calc_tb_clock.sv
      - verification/calc_assert.sv
      - verification/calc_tb.sv

//--- all.f
+incdir+logic
logic/calc_types_pkg.sv
logic/calc_ctrl_pkg.sv
logic/addition.sv
logic/multiply.sv
logic/gencon.sv
logic/calculator_top.sv
verification/calc_tb_clock.sv
verification/calc_assert.sv
verification/calc_tb.sv

//--- logic/addition.sv
// Nibble-serial adder and subtractor with a registered carry between nibbles
`timescale 1ns/10ps
`include "calc_macros.svh"

module addition import calc_types_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  calc_word_t in1,
    input  calc_word_t in2,
    input  logic       sub,
    input  logic       start,
    output calc_word_t out,
    output logic       finish
);

    localparam int NIB_W = `CALC_WIDTH / `CALC_ADD_NIBBLES;
    localparam int CNT_W = $clog2(`CALC_ADD_NIBBLES);
    localparam logic [CNT_W-1:0] LAST_NIB = CNT_W'(`CALC_ADD_NIBBLES - 1);

    calc_word_t a_q;
    calc_word_t b_q;
    calc_word_t sum_q;
    logic carry_q;
    logic busy;
    logic [CNT_W-1:0] nib_cnt;
    logic accept;
    calc_word_t a_cur;
    calc_word_t b_cur;
    logic carry_in;
    logic [NIB_W:0] nib_sum;

    assign accept = start && !busy;

    // First nibble is summed on the start edge, straight from the inputs
    // Inverted in2 plus a carry-in of one gives the two's complement
    assign a_cur    = accept ? in1 : a_q;
    assign b_cur    = accept ? (in2 ^ {`CALC_WIDTH{sub}}) : b_q;
    assign carry_in = accept ? sub : carry_q;

    assign nib_sum = {1'b0, a_cur[NIB_W-1:0]} + {1'b0, b_cur[NIB_W-1:0]}
                   + {{NIB_W{1'b0}}, carry_in};

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            nib_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                nib_cnt <= CNT_W'(1);
            end else if (busy) begin
                nib_cnt <= nib_cnt + 1'b1;
                if (nib_cnt == LAST_NIB) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Operands shift down, sum nibbles enter from the top
    always_ff @(posedge clk) begin
        if (accept || busy) begin
            a_q     <= a_cur >> NIB_W;
            b_q     <= b_cur >> NIB_W;
            carry_q <= nib_sum[NIB_W];
            sum_q   <= {nib_sum[NIB_W-1:0], sum_q[`CALC_WIDTH-1:NIB_W]};
        end
    end

    assign out = sum_q;

endmodule

//--- logic/calc_ctrl_pkg.sv
// Controller state encoding for the calculator sequencing FSM
package calc_ctrl_pkg;

    // Operand entry, dispatch and result states
    typedef enum logic [3:0] {
        ENTER_OP1   = 4'd0,
        SCALE_OP1   = 4'd1,
        ADD_DIGIT1  = 4'd2,
        ENTER_OP2   = 4'd3,
        SCALE_OP2   = 4'd4,
        ADD_DIGIT2  = 4'd5,
        DISPATCH    = 4'd6,
        WAIT_RESULT = 4'd7,
        SHOW        = 4'd8
    } calc_state_t;

endpackage

//--- logic/calc_macros.svh
// Datapath widths and arithmetic unit latencies for the calculator core
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// Arithmetic wraps at this operand and result width
`define CALC_WIDTH 16

// Keypad digit and operator code widths
`define CALC_DIGIT_WIDTH 4
`define CALC_OP_WIDTH 3

// Decimal shift applied per entered digit
`define CALC_RADIX 10

// Cycles from start to finish for each unit
`define CALC_MUL_CYCLES 16
`define CALC_ADD_NIBBLES (`CALC_WIDTH / 4)

`endif

//--- logic/calc_types_pkg.sv
// Datapath types shared by the calculator core and its arithmetic units
`include "calc_macros.svh"

package calc_types_pkg;

    // Operand or result word
    typedef logic [`CALC_WIDTH-1:0] calc_word_t;

    // One decimal digit from the keypad
    typedef logic [`CALC_DIGIT_WIDTH-1:0] calc_digit_t;

    // Any code not listed here acts as no operator
    typedef enum logic [`CALC_OP_WIDTH-1:0] {
        OP_NONE = 3'b000,
        OP_ADD  = 3'b001,
        OP_SUB  = 3'b010,
        OP_MUL  = 3'b100
    } calc_op_t;

endpackage

//--- logic/calculator_top.sv
// Calculator top level exposing the keypad inputs and the binary result
`timescale 1ns/10ps

module calculator_top import calc_types_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  calc_digit_t keypad_input,
    input  logic        read_input,
    input  calc_op_t    operator_input,
    input  logic        equal_input,
    output logic        complete,
    output calc_word_t  display_output
);

    // Controller with its own adder and multiplier
    gencon gencon_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

endmodule

//--- logic/gencon.sv
// Calculator controller for digit entry, operator capture and result dispatch
`timescale 1ns/10ps
`include "calc_macros.svh"

module gencon import calc_types_pkg::*, calc_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        nRST,
    input  calc_digit_t keypad_input,
    input  logic        read_input,
    input  calc_op_t    operator_input,
    input  logic        equal_input,
    output logic        complete,
    output calc_word_t  display_output
);

    calc_state_t state;
    calc_state_t next_state;

    calc_word_t operand1;
    calc_word_t operand2;
    calc_digit_t digit_q;
    calc_word_t digit_ext;

    logic start_add;
    logic start_mul;
    logic add_sub;
    logic use_mul;
    logic op_valid;
    logic unit_done;

    calc_word_t add_out;
    calc_word_t mul_out;
    calc_word_t mul_in1;
    calc_word_t mul_in2;
    logic add_finish;
    logic mul_finish;

    addition add_calc (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (operand1),
        .in2    (operand2),
        .sub    (add_sub),
        .start  (start_add),
        .out    (add_out),
        .finish (add_finish)
    );

    // Shared by decimal scaling and OP_MUL
    multiply mult_calc (
        .clk    (clk),
        .nRST   (nRST),
        .in1    (mul_in1),
        .in2    (mul_in2),
        .start  (start_mul),
        .out    (mul_out),
        .finish (mul_finish)
    );

    // Inputs are sampled while start_mul is high in the first cycle of the state
    assign mul_in1 = (state == SCALE_OP2) ? operand2 : operand1;
    assign mul_in2 = (state == WAIT_RESULT) ? operand2 : calc_word_t'(`CALC_RADIX);

    assign digit_ext = calc_word_t'(digit_q);

    assign op_valid = (operator_input == OP_ADD) || (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    // Only the dispatched unit may end WAIT_RESULT
    assign unit_done = use_mul ? mul_finish : add_finish;

    always_comb begin
        next_state = state;
        case (state)
            ENTER_OP1:   if (read_input) next_state = SCALE_OP1;
            SCALE_OP1:   if (mul_finish) next_state = ADD_DIGIT1;
            ADD_DIGIT1:  next_state = op_valid ? ENTER_OP2 : ENTER_OP1;
            ENTER_OP2:   if (read_input) next_state = SCALE_OP2;
            SCALE_OP2:   if (mul_finish) next_state = ADD_DIGIT2;
            ADD_DIGIT2:  next_state = equal_input ? DISPATCH : ENTER_OP2;
            DISPATCH:    next_state = op_valid ? WAIT_RESULT : ENTER_OP1;
            WAIT_RESULT: if (unit_done) next_state = SHOW;
            SHOW:        next_state = ENTER_OP1;
            default:     next_state = ENTER_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state          <= ENTER_OP1;
            operand1       <= '0;
            operand2       <= '0;
            start_add      <= 1'b0;
            start_mul      <= 1'b0;
            use_mul        <= 1'b0;
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            state     <= next_state;
            start_add <= 1'b0;
            start_mul <= 1'b0;
            complete  <= 1'b0;
            case (state)
                ENTER_OP1, ENTER_OP2: begin
                    if (read_input) begin
                        start_mul <= 1'b1;
                    end
                end
                SCALE_OP1: begin
                    if (mul_finish) begin
                        operand1 <= mul_out;
                    end
                end
                ADD_DIGIT1: operand1 <= operand1 + digit_ext;
                SCALE_OP2: begin
                    if (mul_finish) begin
                        operand2 <= mul_out;
                    end
                end
                ADD_DIGIT2: operand2 <= operand2 + digit_ext;
                DISPATCH: begin
                    case (operator_input)
                        OP_ADD, OP_SUB: begin
                            start_add <= 1'b1;
                            use_mul   <= 1'b0;
                        end
                        OP_MUL: begin
                            start_mul <= 1'b1;
                            use_mul   <= 1'b1;
                        end
                        // Operator dropped before equals abandons the expression
                        default: begin
                            operand1 <= '0;
                            operand2 <= '0;
                        end
                    endcase
                end
                // Result and complete both land in the SHOW cycle
                WAIT_RESULT: begin
                    if (unit_done) begin
                        display_output <= use_mul ? mul_out : add_out;
                        complete       <= 1'b1;
                    end
                end
                SHOW: begin
                    operand1 <= '0;
                    operand2 <= '0;
                end
                default: ;
            endcase
        end
    end

    // Latched digit and subtract select
    always_ff @(posedge clk) begin
        if (read_input && (state == ENTER_OP1 || state == ENTER_OP2)) begin
            digit_q <= keypad_input;
        end
        if (state == DISPATCH) begin
            add_sub <= (operator_input == OP_SUB);
        end
    end

endmodule

//--- logic/multiply.sv
// Radix-2 shift-and-add multiplier with a fixed latency and truncated product
`timescale 1ns/10ps
`include "calc_macros.svh"

module multiply import calc_types_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  calc_word_t in1,
    input  calc_word_t in2,
    input  logic       start,
    output calc_word_t out,
    output logic       finish
);

    localparam int CNT_W = $clog2(`CALC_MUL_CYCLES);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`CALC_MUL_CYCLES - 1);

    calc_word_t mcand_q;
    calc_word_t mplier_q;
    calc_word_t acc_q;
    logic busy;
    logic [CNT_W-1:0] bit_cnt;
    logic accept;
    calc_word_t mcand_cur;
    calc_word_t mplier_cur;
    calc_word_t acc_cur;
    calc_word_t acc_next;

    assign accept = start && !busy;

    // Bit zero of the multiplier is handled on the start edge
    assign mcand_cur  = accept ? in1 : mcand_q;
    assign mplier_cur = accept ? in2 : mplier_q;
    assign acc_cur    = accept ? '0 : acc_q;
    assign acc_next   = mplier_cur[0] ? acc_cur + mcand_cur : acc_cur;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            finish  <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (accept) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Bits shifted past the top of the multiplicand are dropped
    always_ff @(posedge clk) begin
        if (accept || busy) begin
            mcand_q  <= mcand_cur << 1;
            mplier_q <= mplier_cur >> 1;
            acc_q    <= acc_next;
        end
    end

    assign out = acc_q;

endmodule

//--- verification/calc_assert.sv
// Protocol checks on the calculator controller, bound into gencon
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_assert import calc_types_pkg::*, calc_ctrl_pkg::*; (
    input logic        clk,
    input logic        nRST,
    input logic        complete,
    input logic        start_add,
    input logic        start_mul,
    input calc_word_t  display_output,
    input calc_state_t state
);

    // Done strobe is a single cycle
    complete_one_cycle: assert property (
        @(posedge clk) disable iff (!nRST) complete |=> !complete
    ) else $error("complete stayed high for more than one cycle");

    // Arithmetic units are never started together
    start_exclusive: assert property (
        @(posedge clk) disable iff (!nRST) !(start_add && start_mul)
    ) else $error("start_add and start_mul high in the same cycle");

    // Result register only moves with the done strobe
    display_on_complete: assert property (
        @(posedge clk) disable iff (!nRST) $changed(display_output) |-> $rose(complete)
    ) else $error("display_output changed without complete rising");

    // Dispatched unit answers within the multiplier latency
    result_in_time: assert property (
        @(posedge clk) disable iff (!nRST)
            (state == WAIT_RESULT) |-> !$past(state == WAIT_RESULT, `CALC_MUL_CYCLES + 1)
    ) else $error("WAIT_RESULT lasted longer than the multiplier latency");

endmodule

bind gencon calc_assert calc_assert_i (
    .clk            (clk),
    .nRST           (nRST),
    .complete       (complete),
    .start_add      (start_add),
    .start_mul      (start_mul),
    .display_output (display_output),
    .state          (state)
);

//--- verification/calc_tb.sv
// Self-checking testbench for the keypad calculator core
`timescale 1ns/10ps
`include "calc_macros.svh"

module calc_tb import calc_types_pkg::*; ();

    localparam int SEED_INIT = 77681;
    localparam int NUM_RANDOM = 24;
    localparam int MAX_EXPR = 40;
    localparam int MAX_DIGITS = 12;
    localparam int DIGIT_CYCLES = 20;
    localparam int TIMEOUT_CYCLES = MAX_EXPR * MAX_DIGITS * DIGIT_CYCLES + 1000;
    localparam calc_op_t OP_BAD = calc_op_t'(3'b011);

    logic        clk;
    logic        nRST;
    calc_digit_t keypad_input;
    logic        read_input;
    calc_op_t    operator_input;
    logic        equal_input;
    logic        complete;
    calc_word_t  display_output;

    int seed;
    int errors = 0;
    int checks = 0;
    int tests_run = 0;
    int cycles = 0;
    calc_word_t expected_q[$];
    string label_q[$];

    calc_tb_clock clock_gen (
        .clk (clk)
    );

    calculator_top calculator_top_i (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    // Expected result reduced modulo 2^16
    function automatic calc_word_t calc_ref(input longint unsigned a, input longint unsigned b,
                                            input calc_op_t op);
        longint unsigned r;
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_MUL:  r = a * b;
            default: r = 0;
        endcase
        return calc_word_t'(r % (64'd1 << `CALC_WIDTH));
    endfunction

    function automatic string op_symbol(input calc_op_t op);
        case (op)
            OP_ADD:  return "+";
            OP_SUB:  return "-";
            OP_MUL:  return "*";
            default: return "?";
        endcase
    endfunction

    // Called on a rising edge, returns on the next one
    task automatic press_digit(input int d, input logic eq, input calc_op_t op);
        keypad_input   <= calc_digit_t'(d);
        read_input     <= 1'b1;
        operator_input <= op;
        equal_input    <= eq;
        @(posedge clk);
        read_input <= 1'b0;
    endtask

    task automatic enter_number(input int unsigned value, input logic second,
                                input calc_op_t hold_op, input calc_op_t op);
        int digits[$];
        int unsigned rest;
        logic last;
        rest = value;
        do begin
            digits.push_front(rest % 10);
            rest = rest / 10;
        end while (rest != 0);
        foreach (digits[i]) begin
            last = (i == digits.size() - 1);
            if (second) begin
                press_digit(digits[i], last, op);
            end else begin
                // Operator goes valid only for the last digit of operand one
                press_digit(digits[i], 1'b0, last ? op : hold_op);
            end
            if (!(second && last)) begin
                repeat (DIGIT_CYCLES) @(posedge clk);
            end
        end
    endtask

    task automatic wait_complete();
        @(negedge clk);
        while (!complete) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic run_expr(input int unsigned a, input int unsigned b, input calc_op_t op,
                            input calc_op_t hold_op);
        tests_run++;
        expected_q.push_back(calc_ref(a, b, op));
        label_q.push_back($sformatf("%0d %s %0d", a, op_symbol(op), b));
        enter_number(a, 1'b0, hold_op, op);
        enter_number(b, 1'b1, op, op);
        wait_complete();
        operator_input <= OP_NONE;
        equal_input    <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // Compares every result as complete pulses
    initial begin
        calc_word_t exp_val;
        string label;
        forever begin
            @(negedge clk);
            if (nRST && complete) begin
                if (expected_q.size() == 0) begin
                    errors++;
                    $display("Error: complete pulsed at %0t with no expression pending", $time);
                end else begin
                    exp_val = expected_q.pop_front();
                    label = label_q.pop_front();
                    checks++;
                    if (display_output !== exp_val) begin
                        errors++;
                        $display("Error at %0t: display_output = %0d, expected %0d",
                                 $time, display_output, exp_val);
                        $display("expr %0d: %s mismatch", checks, label);
                    end else begin
                        $display("expr %0d: %s = %0d ok", checks, label, display_output);
                    end
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, complete never arrived", cycles);
        $display("test failed");
        $finish;
    end

    initial begin
        int unsigned a;
        int unsigned b;
        calc_op_t op;
        seed = SEED_INIT;
        nRST = 1'b0;
        keypad_input = '0;
        read_input = 1'b0;
        operator_input = OP_NONE;
        equal_input = 1'b0;
        repeat (4) @(posedge clk);
        nRST <= 1'b1;
        @(negedge clk);
        tests_run++;
        checks++;
        if (complete !== 1'b0) begin
            errors++;
            $display("Error at %0t: complete = %0b, expected 0", $time, complete);
        end
        if (display_output !== '0) begin
            errors++;
            $display("Error at %0t: display_output = %0d, expected 0", $time, display_output);
        end
        $display("reset: outputs checked");
        @(posedge clk);

        run_expr(123, 45, OP_ADD, OP_NONE);
        run_expr(4567, 123, OP_SUB, OP_NONE);
        run_expr(12, 345, OP_SUB, OP_NONE);
        run_expr(300, 300, OP_MUL, OP_NONE);
        run_expr(99999, 7, OP_MUL, OP_NONE);
        run_expr(65537, 70000, OP_ADD, OP_NONE);
        // Bad code on the early digits keeps operand one growing
        run_expr(1234, 56, OP_ADD, OP_BAD);
        run_expr(98765, 43, OP_MUL, OP_BAD);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            a = ($random(seed) & 32'h7fffffff) % 10000;
            b = ($random(seed) & 32'h7fffffff) % 10000;
            case (($random(seed) & 32'h7fffffff) % 3)
                0:       op = OP_ADD;
                1:       op = OP_SUB;
                default: op = OP_MUL;
            endcase
            run_expr(a, b, op, (i % 4 == 3) ? OP_BAD : OP_NONE);
        end

        repeat (4) @(posedge clk);
        $display("Summary: %0d of %0d checks done, %0d errors", checks, tests_run, errors);
        if (errors == 0 && checks == tests_run && expected_q.size() == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verification/calc_tb_clock.sv
// Free-running testbench clock with an 8 ns period
`timescale 1ns/10ps

module calc_tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD = 4;

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule
